/* compile.f */
+incdir+verilog
verilog/immu_pkg.sv
verilog/immu_if.sv
verilog/immu_tlb.sv
verilog/immu_walker.sv
verilog/immu_spr.sv
verilog/immu_resolve.sv
verilog/immu_top.sv
tests/tb_page_mem.sv
tests/tb_immu.sv

/* tests/tb_immu.sv */
// Testbench for the instruction MMU that runs SPR, hit, miss, walk and bypass cases on immu_top
`include "immu_defines.svh"

module tb_immu;

   localparam int WAIT_LIMIT = 200;

   logic clk;
   logic rst;
   logic xlat_req;
   logic [31:0] xlat_va;
   logic supervisor;
   logic xlat_ack;
   logic [31:0] xlat_pa;
   logic xlat_ci;
   logic xlat_miss;
   logic xlat_fault;
   logic enable;
   logic mem_req;
   logic [31:0] mem_addr;
   logic mem_ack;
   logic [31:0] mem_data;
   logic spr_stb;
   logic spr_we;
   logic [15:0] spr_addr;
   logic [31:0] spr_wdat;
   logic [31:0] spr_rdat;
   logic spr_ack;

   int errors;
   int tests;
   int failed_tests;
   int errors_at_start;
   int requests_before;
   int res_cycles;
   logic [31:0] spr_result;
   logic [31:0] res_pa;
   logic res_ci;
   logic res_miss;
   logic res_fault;
   logic [31:0] va;
   logic [31:0] base;
   logic [31:0] ptr;
   logic [31:0] pte;

   immu_top dut_i (
      .clk          (clk),
      .rst          (rst),
      .xlat_req_i   (xlat_req),
      .xlat_va_i    (xlat_va),
      .supervisor_i (supervisor),
      .xlat_ack_o   (xlat_ack),
      .xlat_pa_o    (xlat_pa),
      .xlat_ci_o    (xlat_ci),
      .xlat_miss_o  (xlat_miss),
      .xlat_fault_o (xlat_fault),
      .enable_i     (enable),
      .mem_req_o    (mem_req),
      .mem_addr_o   (mem_addr),
      .mem_ack_i    (mem_ack),
      .mem_data_i   (mem_data),
      .spr_stb_i    (spr_stb),
      .spr_we_i     (spr_we),
      .spr_addr_i   (spr_addr),
      .spr_dat_i    (spr_wdat),
      .spr_dat_o    (spr_rdat),
      .spr_ack_o    (spr_ack)
   );

   tb_page_mem #(.SEED(32'd12430)) mem_i (
      .clk        (clk),
      .rst        (rst),
      .mem_req_i  (mem_req),
      .mem_addr_i (mem_addr),
      .mem_ack_o  (mem_ack),
      .mem_data_o (mem_data)
   );

   always #2 clk = ~clk;

   // Handshake rules on all three ports
   fetch_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      xlat_ack |-> $past(xlat_req))
      else begin
         $display("Fetch ack was high without a request");
         errors++;
      end
   fetch_ack_holds: assert property (@(posedge clk) disable iff (rst)
      xlat_ack && xlat_req |=> xlat_ack)
      else begin
         $display("Fetch ack dropped while the request was still high");
         errors++;
      end
   fetch_ack_releases: assert property (@(posedge clk) disable iff (rst)
      xlat_ack && !xlat_req |=> !xlat_ack)
      else begin
         $display("Fetch ack stayed high after the request dropped");
         errors++;
      end
   mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
      mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
      else begin
         $display("Memory request or address changed before ack");
         errors++;
      end
   mem_req_drops: assert property (@(posedge clk) disable iff (rst)
      mem_req && mem_ack |=> !mem_req)
      else begin
         $display("Memory request still high after ack");
         errors++;
      end
   spr_ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
      spr_ack |-> $past(spr_stb))
      else begin
         $display("SPR ack was high without a strobe");
         errors++;
      end
   spr_ack_holds: assert property (@(posedge clk) disable iff (rst)
      spr_ack && spr_stb |=> spr_ack)
      else begin
         $display("SPR ack dropped while the strobe was still high");
         errors++;
      end

   function automatic logic [15:0] set_of(input logic [31:0] a);
      return 16'(a[18:13]);
   endfunction

   function automatic logic [31:0] pack_match(input logic [31:0] a);
      return {a[31:13], 12'h000, 1'b1};
   endfunction

   function automatic logic [31:0] pack_trans(input logic [18:0] ppn, input logic uxe,
                                              input logic sxe, input logic [5:0] attr);
      return {ppn, 5'b00000, uxe, sxe, attr};
   endfunction

   task automatic finish_run();
      $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   endtask

   task automatic give_up(input string what);
      $display("Timed out waiting for %s", what);
      errors++;
      finish_run();
   endtask

   task automatic expect_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic close_test(input string name);
      tests++;
      if (errors == errors_at_start) begin
         $display("Test %0d %s: ok", tests, name);
      end else begin
         failed_tests++;
         $display("Test %0d %s: %0d errors", tests, name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic spr_access(input logic we, input logic [15:0] addr, input logic [31:0] data);
      int n;
      spr_stb = 1'b1;
      spr_we = we;
      spr_addr = addr;
      spr_wdat = data;
      n = 0;
      while (!spr_ack) begin
         if (n == WAIT_LIMIT) begin
            give_up("SPR ack");
         end else begin
            step();
            n++;
         end
      end
      spr_result = spr_rdat;
      // Strobe stays up one more cycle while ack is high
      step();
      spr_stb = 1'b0;
      spr_we = 1'b0;
      n = 0;
      while (spr_ack) begin
         if (n == WAIT_LIMIT) begin
            give_up("SPR ack release");
         end else begin
            step();
            n++;
         end
      end
   endtask

   // One idle cycle first so that an idle resolver sees the request
   task automatic translate(input logic [31:0] addr, input logic sup);
      int n;
      step();
      xlat_va = addr;
      supervisor = sup;
      xlat_req = 1'b1;
      res_cycles = 0;
      while (!xlat_ack) begin
         if (res_cycles == WAIT_LIMIT) begin
            give_up("fetch ack");
         end else begin
            step();
            res_cycles++;
         end
      end
      res_pa = xlat_pa;
      res_ci = xlat_ci;
      res_miss = xlat_miss;
      res_fault = xlat_fault;
      // Request stays up one more cycle while ack is high
      step();
      xlat_req = 1'b0;
      n = 0;
      while (xlat_ack) begin
         if (n == WAIT_LIMIT) begin
            give_up("fetch ack release");
         end else begin
            step();
            n++;
         end
      end
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      xlat_req = 1'b0;
      xlat_va = '0;
      supervisor = 1'b0;
      enable = 1'b1;
      spr_stb = 1'b0;
      spr_we = 1'b0;
      spr_addr = '0;
      spr_wdat = '0;
      errors = 0;
      tests = 0;
      failed_tests = 0;
      errors_at_start = 0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;

      spr_access(1'b1, `IMMU_SPR_CR_ADDR, 32'hABCD_E400);
      spr_access(1'b0, `IMMU_SPR_CR_ADDR, 32'h0);
      expect_value("spr_dat_o control", spr_result, 32'hABCD_E400);
      spr_access(1'b1, `IMMU_SPR_MATCH_BASE | 16'd5, 32'h1234_6001);
      spr_access(1'b1, `IMMU_SPR_TRANS_BASE | 16'd5, 32'h0BAD_F0C2);
      spr_access(1'b0, `IMMU_SPR_MATCH_BASE | 16'd5, 32'h0);
      expect_value("spr_dat_o match", spr_result, 32'h1234_6001);
      spr_access(1'b0, `IMMU_SPR_TRANS_BASE | 16'd5, 32'h0);
      expect_value("spr_dat_o translate", spr_result, 32'h0BAD_F0C2);
      spr_access(1'b1, `IMMU_SPR_CR_ADDR, 32'h0);
      spr_access(1'b0, `IMMU_SPR_CR_ADDR, 32'h0);
      expect_value("spr_dat_o control", spr_result, 32'h0);
      close_test("SPR readback");

      // Supervisor-only page with cache inhibit, then user-only page
      va = 32'h4002_A123;
      spr_access(1'b1, `IMMU_SPR_MATCH_BASE | set_of(va), pack_match(va));
      spr_access(1'b1, `IMMU_SPR_TRANS_BASE | set_of(va),
                 pack_trans(19'h31F00, 1'b0, 1'b1, 6'h02));
      translate(va, 1'b1);
      expect_value("xlat_pa_o", res_pa, {19'h31F00, va[12:0]});
      expect_value("xlat_ci_o", res_ci, 1'b1);
      expect_value("xlat_fault_o", res_fault, 1'b0);
      expect_value("xlat_miss_o", res_miss, 1'b0);
      expect_value("xlat_ack_o hit latency", res_cycles, 2);
      translate(va, 1'b0);
      expect_value("xlat_fault_o", res_fault, 1'b1);
      spr_access(1'b1, `IMMU_SPR_TRANS_BASE | set_of(va),
                 pack_trans(19'h31F00, 1'b1, 1'b0, 6'h00));
      translate(va, 1'b1);
      expect_value("xlat_fault_o", res_fault, 1'b1);
      translate(va, 1'b0);
      expect_value("xlat_fault_o", res_fault, 1'b0);
      expect_value("xlat_ci_o", res_ci, 1'b0);
      expect_value("xlat_pa_o", res_pa, {19'h31F00, va[12:0]});
      close_test("SPR built hit and permissions");

      requests_before = mem_i.requests;
      translate(32'h0000_4000, 1'b1);
      expect_value("xlat_miss_o", res_miss, 1'b1);
      expect_value("xlat_fault_o", res_fault, 1'b0);
      expect_value("xlat_ack_o miss latency", res_cycles, 2);
      expect_value("mem_req_o count", mem_i.requests - requests_before, 0);
      close_test("miss without walk");

      // Executable in supervisor mode only and cache inhibited
      base = 32'h0010_0000;
      va = 32'h8765_4321;
      ptr = 32'h0008_0000;
      pte = {19'h54C21, 13'h0502};
      mem_i.load_word({base[31:10], va[31:24], 2'b00}, ptr);
      mem_i.load_word({ptr[31:13], va[23:13], 2'b00}, pte);
      spr_access(1'b1, `IMMU_SPR_CR_ADDR, base);
      requests_before = mem_i.requests;
      translate(va, 1'b1);
      expect_value("xlat_pa_o", res_pa, {19'h54C21, va[12:0]});
      expect_value("xlat_ci_o", res_ci, 1'b1);
      expect_value("xlat_fault_o", res_fault, 1'b0);
      expect_value("xlat_miss_o", res_miss, 1'b0);
      expect_value("mem_req_o count", mem_i.requests - requests_before, 2);
      spr_access(1'b0, `IMMU_SPR_TRANS_BASE | set_of(va), 32'h0);
      expect_value("spr_dat_o translate",
                   spr_result, pack_trans(19'h54C21, 1'b0, 1'b1, 6'h02));
      spr_access(1'b0, `IMMU_SPR_MATCH_BASE | set_of(va), 32'h0);
      expect_value("spr_dat_o match", spr_result, pack_match(va));
      requests_before = mem_i.requests;
      translate(va, 1'b0);
      expect_value("xlat_fault_o", res_fault, 1'b1);
      expect_value("xlat_ack_o hit latency", res_cycles, 2);
      translate(va, 1'b1);
      expect_value("xlat_fault_o", res_fault, 1'b0);
      expect_value("xlat_pa_o", res_pa, {19'h54C21, va[12:0]});
      expect_value("xlat_ack_o hit latency", res_cycles, 2);
      expect_value("mem_req_o count", mem_i.requests - requests_before, 0);
      close_test("table walk refill");

      // No pointer loaded for this directory slot
      va = 32'h1100_6000;
      requests_before = mem_i.requests;
      translate(va, 1'b1);
      expect_value("xlat_fault_o", res_fault, 1'b1);
      expect_value("xlat_miss_o", res_miss, 1'b0);
      expect_value("mem_req_o count", mem_i.requests - requests_before, 1);
      spr_access(1'b0, `IMMU_SPR_MATCH_BASE | set_of(va), 32'h0);
      expect_value("spr_dat_o match valid", spr_result[0], 1'b0);
      va = 32'h8700_8000;
      mem_i.load_word({ptr[31:13], va[23:13], 2'b00}, 32'h0024_6100);
      requests_before = mem_i.requests;
      translate(va, 1'b1);
      expect_value("xlat_fault_o", res_fault, 1'b1);
      expect_value("mem_req_o count", mem_i.requests - requests_before, 2);
      spr_access(1'b0, `IMMU_SPR_MATCH_BASE | set_of(va), 32'h0);
      expect_value("spr_dat_o match valid", spr_result[0], 1'b0);
      close_test("walk faults");

      enable = 1'b0;
      translate(32'hDEAD_BEEF, 1'b0);
      expect_value("xlat_pa_o", res_pa, 32'hDEAD_BEEF);
      expect_value("xlat_fault_o", res_fault, 1'b0);
      expect_value("xlat_miss_o", res_miss, 1'b0);
      expect_value("xlat_ack_o bypass latency", res_cycles, 1);
      enable = 1'b1;
      step();
      expect_value("xlat_ack_o", xlat_ack, 1'b0);
      close_test("handshakes and bypass");

      finish_run();
   end

endmodule

/* tests/tb_page_mem.sv */
// Page table memory model for the testbench, answers the walker's four-phase port after a random delay
module tb_page_mem #(
   parameter logic [31:0] SEED = 32'd12430
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        mem_req_i,
   input  logic [31:0] mem_addr_i,
   output logic        mem_ack_o,
   output logic [31:0] mem_data_o
);

   // Sparse storage, unwritten words read as zero
   logic [31:0] words [logic [31:0]];
   logic [31:0] rnd;
   logic [1:0] wait_left;
   logic pending;
   int requests;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
      words[addr] = data;
   endtask

   // Responds a small delay after each rising edge
   initial begin
      mem_ack_o = 1'b0;
      mem_data_o = '0;
      rnd = SEED;
      wait_left = '0;
      pending = 1'b0;
      requests = 0;
      forever begin
         @(posedge clk);
         #1;
         if (rst) begin
            mem_ack_o = 1'b0;
            pending = 1'b0;
         end else if (mem_ack_o) begin
            if (!mem_req_i) begin
               mem_ack_o = 1'b0;
            end
         end else if (mem_req_i) begin
            if (!pending) begin
               rnd = lcg_step(rnd);
               wait_left = rnd[17:16];
               pending = 1'b1;
               requests++;
            end
            if (wait_left == 0) begin
               mem_data_o = words.exists(mem_addr_i) ? words[mem_addr_i] : 32'h0;
               mem_ack_o = 1'b1;
               pending = 1'b0;
            end else begin
               wait_left = wait_left - 2'd1;
            end
         end
      end
   end

endmodule

/* verilog/immu_top.sv */
// Instruction MMU top level, joins TLB, walker, SPR slave and resolver behind plain ports
`include "immu_defines.svh"

module immu_top (
   input  logic        clk,
   input  logic        rst,
   // Fetch translation port
   input  logic        xlat_req_i,
   input  logic [31:0] xlat_va_i,
   input  logic        supervisor_i,
   output logic        xlat_ack_o,
   output logic [31:0] xlat_pa_o,
   output logic        xlat_ci_o,
   output logic        xlat_miss_o,
   output logic        xlat_fault_o,
   input  logic        enable_i,
   // Page table memory
   output logic        mem_req_o,
   output logic [31:0] mem_addr_o,
   input  logic        mem_ack_i,
   input  logic [31:0] mem_data_i,
   // SPR bus
   input  logic        spr_stb_i,
   input  logic        spr_we_i,
   input  logic [15:0] spr_addr_i,
   input  logic [31:0] spr_dat_i,
   output logic [31:0] spr_dat_o,
   output logic        spr_ack_o
);

   logic [21:0] ptbr;
   logic walk_start;
   logic walk_done;
   logic walk_fault;
   logic walk_busy;
   logic [`IMMU_SET_WIDTH-1:0] spr_rd_set;
   immu_pkg::match_word_t spr_rd_match;
   immu_pkg::trans_word_t spr_rd_trans;

   tlb_wr_if walk_wr_if ();
   tlb_wr_if spr_wr_if ();
   tlb_lookup_if lookup_if ();

   immu_tlb tlb_i (
      .clk            (clk),
      .rst            (rst),
      .walk_wr        (walk_wr_if.receiver),
      .spr_wr         (spr_wr_if.receiver),
      .lookup         (lookup_if.tlb),
      .spr_rd_set_i   (spr_rd_set),
      .spr_rd_match_o (spr_rd_match),
      .spr_rd_trans_o (spr_rd_trans)
   );

   immu_walker walker_i (
      .clk        (clk),
      .rst        (rst),
      .start_i    (walk_start),
      .va_i       (xlat_va_i),
      .ptbr_i     (ptbr),
      .done_o     (walk_done),
      .fault_o    (walk_fault),
      .busy_o     (walk_busy),
      .mem_req_o  (mem_req_o),
      .mem_addr_o (mem_addr_o),
      .mem_ack_i  (mem_ack_i),
      .mem_data_i (mem_data_i),
      .wr         (walk_wr_if.writer)
   );

   immu_spr spr_i (
      .clk           (clk),
      .rst           (rst),
      .stb_i         (spr_stb_i),
      .we_i          (spr_we_i),
      .addr_i        (spr_addr_i),
      .dat_i         (spr_dat_i),
      .dat_o         (spr_dat_o),
      .ack_o         (spr_ack_o),
      .walker_busy_i (walk_busy),
      .ptbr_o        (ptbr),
      .rd_set_o      (spr_rd_set),
      .rd_match_i    (spr_rd_match),
      .rd_trans_i    (spr_rd_trans),
      .wr            (spr_wr_if.writer)
   );

   immu_resolve resolve_i (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .req_i        (xlat_req_i),
      .va_i         (xlat_va_i),
      .supervisor_i (supervisor_i),
      .ack_o        (xlat_ack_o),
      .pa_o         (xlat_pa_o),
      .ci_o         (xlat_ci_o),
      .miss_o       (xlat_miss_o),
      .fault_o      (xlat_fault_o),
      .ptbr_i       (ptbr),
      .lookup       (lookup_if.resolver),
      .walk_start_o (walk_start),
      .walk_done_i  (walk_done),
      .walk_fault_i (walk_fault)
   );

endmodule

/* verilog/immu_resolve.sv */
// Fetch translation FSM, compares the TLB entry, checks execute rights and launches walks
`include "immu_defines.svh"

module immu_resolve (
   input  logic           clk,
   input  logic           rst,
   input  logic           enable_i,
   input  logic           req_i,
   input  logic [31:0]    va_i,
   input  logic           supervisor_i,
   output logic           ack_o,
   output logic [31:0]    pa_o,
   output logic           ci_o,
   output logic           miss_o,
   output logic           fault_o,
   input  logic [21:0]    ptbr_i,
   tlb_lookup_if.resolver lookup,
   output logic           walk_start_o,
   input  logic           walk_done_i,
   input  logic           walk_fault_i
);

   immu_pkg::xlat_state_e state_q;
   logic hit;
   logic exec_ok;
   logic base_set;
   logic miss_q;
   logic fault_q;

   assign lookup.set = va_i[`IMMU_PAGE_BITS +: `IMMU_SET_WIDTH];
   assign hit = lookup.match.valid && lookup.match.vpn == va_i[31:`IMMU_PAGE_BITS];
   assign exec_ok = supervisor_i ? lookup.trans.sxe : lookup.trans.uxe;
   assign base_set = ptbr_i != '0;
   assign walk_start_o = state_q == immu_pkg::XLAT_LOOKUP && !hit && base_set;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= immu_pkg::XLAT_IDLE;
         miss_q <= 1'b0;
         fault_q <= 1'b0;
      end else begin
         case (state_q)
            immu_pkg::XLAT_IDLE: begin
               if (req_i) begin
                  state_q <= enable_i ? immu_pkg::XLAT_LOOKUP : immu_pkg::XLAT_RESPOND;
               end
            end
            immu_pkg::XLAT_LOOKUP: begin
               if (hit) begin
                  fault_q <= !exec_ok;
                  state_q <= immu_pkg::XLAT_RESPOND;
               end else if (base_set) begin
                  state_q <= immu_pkg::XLAT_WALK;
               end else begin
                  miss_q <= 1'b1;
                  state_q <= immu_pkg::XLAT_RESPOND;
               end
            end
            immu_pkg::XLAT_WALK: begin
               if (walk_fault_i) begin
                  fault_q <= 1'b1;
                  state_q <= immu_pkg::XLAT_RESPOND;
               end else if (walk_done_i) begin
                  // Entry is written, read it again
                  state_q <= immu_pkg::XLAT_LOOKUP;
               end
            end
            immu_pkg::XLAT_RESPOND: begin
               if (!req_i) begin
                  state_q <= immu_pkg::XLAT_RELEASE;
               end
            end
            immu_pkg::XLAT_RELEASE: begin
               miss_q <= 1'b0;
               fault_q <= 1'b0;
               state_q <= immu_pkg::XLAT_IDLE;
            end
            default: state_q <= immu_pkg::XLAT_IDLE;
         endcase
      end
   end

   // Result address, bypass passes va straight through
   always_ff @(posedge clk) begin
      if (state_q == immu_pkg::XLAT_IDLE && req_i && !enable_i) begin
         pa_o <= va_i;
         ci_o <= 1'b0;
      end else if (state_q == immu_pkg::XLAT_LOOKUP && hit) begin
         pa_o <= {lookup.trans.ppn, va_i[`IMMU_PAGE_BITS-1:0]};
         ci_o <= lookup.ci;
      end
   end

   assign ack_o = state_q == immu_pkg::XLAT_RESPOND;
   assign miss_o = miss_q;
   assign fault_o = fault_q;

endmodule

/* verilog/immu_spr.sv */
// SPR bus slave for the MMU control register and the ITLB match and translate words
`include "immu_defines.svh"

module immu_spr (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  logic [15:0]                addr_i,
   input  logic [31:0]                dat_i,
   output logic [31:0]                dat_o,
   output logic                       ack_o,
   input  logic                       walker_busy_i,
   output logic [21:0]                ptbr_o,
   output logic [`IMMU_SET_WIDTH-1:0] rd_set_o,
   input  immu_pkg::match_word_t      rd_match_i,
   input  immu_pkg::trans_word_t      rd_trans_i,
   tlb_wr_if.writer                   wr
);

   localparam logic [15:0] SET_MASK = 16'((1 << `IMMU_SET_WIDTH) - 1);

   logic grp_hit;
   logic cr_sel;
   logic match_sel;
   logic trans_sel;
   logic fire;
   logic ack_q;
   logic [31:0] cr_q;
   logic [31:0] rd_data;

   assign grp_hit = addr_i[15:11] == `IMMU_SPR_GROUP;
   assign cr_sel = addr_i == `IMMU_SPR_CR_ADDR;
   assign match_sel = (addr_i & ~SET_MASK) == `IMMU_SPR_MATCH_BASE;
   assign trans_sel = (addr_i & ~SET_MASK) == `IMMU_SPR_TRANS_BASE;

   // Access completes on the edge where ack rises, held off during a walk
   assign fire = stb_i && grp_hit && !ack_q && !walker_busy_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
         cr_q <= '0;
      end else begin
         ack_q <= stb_i && grp_hit && (ack_q || !walker_busy_i);
         if (fire && we_i && cr_sel) begin
            cr_q <= dat_i;
         end
      end
   end

   always_comb begin
      if (cr_sel) begin
         rd_data = cr_q;
      end else if (match_sel) begin
         rd_data = rd_match_i;
      end else if (trans_sel) begin
         rd_data = rd_trans_i;
      end else begin
         rd_data = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         dat_o <= rd_data;
      end
   end

   // Each register write keeps the other word of the entry
   assign rd_set_o = addr_i[`IMMU_SET_WIDTH-1:0];
   assign wr.we = fire && we_i && (match_sel || trans_sel);
   assign wr.set = addr_i[`IMMU_SET_WIDTH-1:0];
   assign wr.match = match_sel ? immu_pkg::match_word_t'(dat_i) : rd_match_i;
   assign wr.trans = trans_sel ? immu_pkg::trans_word_t'(dat_i) : rd_trans_i;

   assign ack_o = ack_q;
   assign ptbr_o = cr_q[31:10];

endmodule

/* verilog/immu_walker.sv */
// Two-level page table walker that refills the ITLB over a four-phase memory port
`include "immu_defines.svh"

module immu_walker (
   input  logic        clk,
   input  logic        rst,
   input  logic        start_i,
   input  logic [31:0] va_i,
   input  logic [21:0] ptbr_i,
   output logic        done_o,
   output logic        fault_o,
   output logic        busy_o,
   output logic        mem_req_o,
   output logic [31:0] mem_addr_o,
   input  logic        mem_ack_i,
   input  logic [31:0] mem_data_i,
   tlb_wr_if.writer    wr
);

   immu_pkg::walk_state_e state_q;
   logic [31:0] data_q;
   logic fault_q;
   logic beat_done;
   immu_pkg::match_word_t match_w;
   immu_pkg::trans_word_t trans_w;

   // Request dropped and memory has released its ack
   assign beat_done = !mem_req_o && !mem_ack_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= immu_pkg::WALK_IDLE;
         mem_req_o <= 1'b0;
         fault_q <= 1'b0;
      end else begin
         fault_q <= 1'b0;
         case (state_q)
            immu_pkg::WALK_IDLE: begin
               if (start_i) begin
                  mem_req_o <= 1'b1;
                  state_q <= immu_pkg::WALK_PTR;
               end
            end
            immu_pkg::WALK_PTR: begin
               if (beat_done) begin
                  // Pointer to a null page table
                  if (data_q[31:`IMMU_PAGE_BITS] == '0) begin
                     fault_q <= 1'b1;
                     state_q <= immu_pkg::WALK_IDLE;
                  end else begin
                     mem_req_o <= 1'b1;
                     state_q <= immu_pkg::WALK_PTE;
                  end
               end
            end
            immu_pkg::WALK_PTE: begin
               if (beat_done) begin
                  // Present bit
                  if (!data_q[10]) begin
                     fault_q <= 1'b1;
                     state_q <= immu_pkg::WALK_IDLE;
                  end else begin
                     state_q <= immu_pkg::WALK_WRITE;
                  end
               end
            end
            immu_pkg::WALK_WRITE: state_q <= immu_pkg::WALK_SETTLE;
            immu_pkg::WALK_SETTLE: state_q <= immu_pkg::WALK_IDLE;
            default: state_q <= immu_pkg::WALK_IDLE;
         endcase
         if (mem_req_o && mem_ack_i) begin
            mem_req_o <= 1'b0;
         end
      end
   end

   // Address and returned word
   always_ff @(posedge clk) begin
      if (state_q == immu_pkg::WALK_IDLE && start_i) begin
         mem_addr_o <= {ptbr_i, va_i[31:24], 2'b00};
      end else if (state_q == immu_pkg::WALK_PTR && beat_done) begin
         mem_addr_o <= {data_q[31:`IMMU_PAGE_BITS], va_i[23:`IMMU_PAGE_BITS], 2'b00};
      end
      if (mem_req_o && mem_ack_i) begin
         data_q <= mem_data_i;
      end
   end

   // PTE bits: X is 8, U is 6
   always_comb begin
      trans_w = '0;
      trans_w.ppn = data_q[31:`IMMU_PAGE_BITS];
      trans_w.sxe = data_q[8];
      trans_w.uxe = data_q[8] & data_q[6];
      trans_w.attr = data_q[5:0];
      match_w = '0;
      match_w.vpn = va_i[31:`IMMU_PAGE_BITS];
      match_w.valid = 1'b1;
   end

   // The fetch address is held by the requester for the whole walk
   assign wr.we = state_q == immu_pkg::WALK_WRITE;
   assign wr.set = va_i[`IMMU_PAGE_BITS +: `IMMU_SET_WIDTH];
   assign wr.match = match_w;
   assign wr.trans = trans_w;

   assign done_o = state_q == immu_pkg::WALK_SETTLE;
   assign fault_o = fault_q;
   assign busy_o = state_q != immu_pkg::WALK_IDLE;

endmodule

/* verilog/immu_tlb.sv */
// Direct-mapped ITLB storage serving the fetch lookup, SPR reads and walker or SPR writes
`include "immu_defines.svh"

module immu_tlb (
   input  logic                       clk,
   input  logic                       rst,
   tlb_wr_if.receiver                 walk_wr,
   tlb_wr_if.receiver                 spr_wr,
   tlb_lookup_if.tlb                  lookup,
   input  logic [`IMMU_SET_WIDTH-1:0] spr_rd_set_i,
   output immu_pkg::match_word_t      spr_rd_match_o,
   output immu_pkg::trans_word_t      spr_rd_trans_o
);

   localparam int SETS = 1 << `IMMU_SET_WIDTH;

   immu_pkg::match_word_t match_mem [SETS];
   immu_pkg::trans_word_t trans_mem [SETS];
   logic [SETS-1:0] valid_q;

   logic wr_we;
   logic [`IMMU_SET_WIDTH-1:0] wr_set;
   immu_pkg::match_word_t wr_match;
   immu_pkg::trans_word_t wr_trans;

   // Walker has priority over the SPR port
   always_comb begin
      wr_we = walk_wr.we | spr_wr.we;
      if (walk_wr.we) begin
         wr_set = walk_wr.set;
         wr_match = walk_wr.match;
         wr_trans = walk_wr.trans;
      end else begin
         wr_set = spr_wr.set;
         wr_match = spr_wr.match;
         wr_trans = spr_wr.trans;
      end
   end

   // Valid bits live apart from the arrays so reset can clear them
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
      end else if (wr_we) begin
         valid_q[wr_set] <= wr_match.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_we) begin
         match_mem[wr_set] <= wr_match;
         trans_mem[wr_set] <= wr_trans;
      end
   end

   // Fetch side read, one cycle latency
   always_ff @(posedge clk) begin
      lookup.match <= {match_mem[lookup.set][31:1], valid_q[lookup.set]};
      lookup.trans <= trans_mem[lookup.set];
      lookup.ci <= trans_mem[lookup.set].attr[1];
   end

   // SPR side read is combinational
   assign spr_rd_match_o = {match_mem[spr_rd_set_i][31:1], valid_q[spr_rd_set_i]};
   assign spr_rd_trans_o = trans_mem[spr_rd_set_i];

endmodule

/* verilog/immu_if.sv */
// TLB write and lookup bundles that connect the MMU blocks inside the design
`include "immu_defines.svh"

// One write strobe with its set index and both words
interface tlb_wr_if;
   logic we;
   logic [`IMMU_SET_WIDTH-1:0] set;
   immu_pkg::match_word_t match;
   immu_pkg::trans_word_t trans;

   modport writer (
      output we,
      output set,
      output match,
      output trans
   );

   modport receiver (
      input we,
      input set,
      input match,
      input trans
   );
endinterface

// Registered lookup, data arrives one cycle after set
interface tlb_lookup_if;
   logic [`IMMU_SET_WIDTH-1:0] set;
   immu_pkg::match_word_t match;
   immu_pkg::trans_word_t trans;
   logic ci;

   modport tlb (
      input set,
      output match,
      output trans,
      output ci
   );

   modport resolver (
      output set,
      input match,
      input trans,
      input ci
   );
endinterface

/* verilog/immu_pkg.sv */
// Shared FSM state types and TLB word layouts for the instruction MMU blocks
`include "immu_defines.svh"

package immu_pkg;

   // Fetch translation FSM
   typedef enum logic [2:0] {
      XLAT_IDLE,
      XLAT_LOOKUP,
      XLAT_WALK,
      XLAT_RESPOND,
      XLAT_RELEASE
   } xlat_state_e;

   // Hardware table walk FSM
   typedef enum logic [2:0] {
      WALK_IDLE,
      WALK_PTR,
      WALK_PTE,
      WALK_WRITE,
      WALK_SETTLE
   } walk_state_e;

   typedef struct packed {
      logic [31:`IMMU_PAGE_BITS] vpn;
      logic [`IMMU_PAGE_BITS-2:0] rsvd;
      logic valid;
   } match_word_t;

   // attr[1] is cache inhibit
   typedef struct packed {
      logic [31:`IMMU_PAGE_BITS] ppn;
      logic [`IMMU_PAGE_BITS-9:0] rsvd;
      logic uxe;
      logic sxe;
      logic [5:0] attr;
   } trans_word_t;

endpackage

/* verilog/immu_defines.svh */
// Instruction MMU geometry and SPR address map, included by every block that decodes them
`ifndef IMMU_DEFINES_SVH
`define IMMU_DEFINES_SVH

// 64 sets of 8 KB pages
`define IMMU_SET_WIDTH 6
`define IMMU_PAGE_BITS 13

// SPR group number, found in address bits 15:11
`define IMMU_SPR_GROUP 5'd2

// Group 2 starts at 0x1000
`define IMMU_SPR_CR_ADDR 16'h1000
`define IMMU_SPR_MATCH_BASE 16'h1200
`define IMMU_SPR_TRANS_BASE 16'h1280

`endif
